/* source/conv_pkg.sv */
/*
  Sizes and beat layouts shared by the processing engine and its testbench.
  Sums are signed, and WORD_WIDTH_ACC must hold the longest group of products.
*/
`default_nettype none

package conv_pkg;

  // ====================================================================
  // sizes
  // ====================================================================
  localparam int ROWS                = 4;  // pixel lanes.
  localparam int COLS                = 2;  // weight lanes.
  localparam int WORD_WIDTH          = 8;
  localparam int WORD_WIDTH_ACC      = 20;
  localparam int LATENCY_MULTIPLIER  = 2;
  localparam int LATENCY_ACCUMULATOR = 1;
  localparam int TAG_WIDTH           = 4;

  // ====================================================================
  // beats and control
  // ====================================================================
  typedef struct packed {
    logic                 is_sum_start;  // first beat of a group.
    logic                 is_cin_last;   // the last beat of a group sends the sums out.
    logic [TAG_WIDTH-1:0] tag;
  } tuser_st;

  typedef struct packed {
    logic [ROWS-1:0][WORD_WIDTH-1:0] pixels;
    logic [COLS-1:0][WORD_WIDTH-1:0] weights;
    tuser_st                         user;
    logic                            last;
  } in_beat_st;

  typedef struct packed {
    logic [COLS-1:0][ROWS-1:0][WORD_WIDTH_ACC-1:0] sums;
    logic [TAG_WIDTH-1:0]                          tag;
    logic                                          last;
  } out_beat_st;

  typedef struct packed {
    logic    valid;
    logic    last;
    tuser_st user;
  } mul_ctrl_st;

  typedef struct packed {
    logic                 valid;
    logic                 last;
    logic [TAG_WIDTH-1:0] tag;
  } acc_ctrl_st;

endpackage

`default_nettype wire

/* source/n_delay.sv */
/*
  Clock-enabled delay line of N stages for any packed payload type T.
  All stages clear to zero on reset. N of 0 gives a plain wire.
*/
`timescale 1ns/1ps
`default_nettype none

module n_delay #(
  parameter int  N = 1,
  parameter type T = logic
) (
  input  wire  clk,
  input  wire  i_rst_n,
  input  wire  i_clken,
  input  T     i_data,
  output T     o_data
);

  generate
    if (N == 0) begin : g_wire
      assign o_data = i_data;
    end else begin : g_chain
      T stage_q [N];

      always_ff @(posedge clk) begin
        if (!i_rst_n) begin
          for (int i = 0; i < N; i++) begin
            stage_q[i] <= '0;
          end
        end else if (i_clken) begin
          stage_q[0] <= i_data;
          for (int i = 1; i < N; i++) begin
            stage_q[i] <= stage_q[i-1];  // the whole chain moves as one.
          end
        end
      end

      assign o_data = stage_q[N-1];
    end
  endgenerate

endmodule

`default_nettype wire

/* source/proc_element.sv */
/*
  One multiply-accumulate element. Needs LATENCY_MULTIPLIER of at least 1 and
  a single accumulator register. Empty slots enter the product pipe as zero.
*/
`timescale 1ns/1ps
`default_nettype none

module proc_element (
  input  wire                                        clk,
  input  wire                                        i_rst_n,
  input  wire                                        i_en,
  input  wire                                        i_clken_mul,
  input  wire  signed [conv_pkg::WORD_WIDTH-1:0]     i_pixel,
  input  wire  signed [conv_pkg::WORD_WIDTH-1:0]     i_weight,
  input  wire                                        i_bypass,
  output logic signed [conv_pkg::WORD_WIDTH_ACC-1:0] o_sum
);
  import conv_pkg::*;

  localparam int PROD_WIDTH = 2 * WORD_WIDTH;

  logic signed [PROD_WIDTH-1:0]     mul_q [LATENCY_MULTIPLIER];
  logic signed [WORD_WIDTH_ACC-1:0] product_ext;

  // a stage only moves under the shared enable, so a stalled pipe keeps its slots.
  always_ff @(posedge clk) begin
    if (i_en) begin
      mul_q[0] <= i_clken_mul ? i_pixel * i_weight : PROD_WIDTH'(0);  // a bubble adds nothing.
      for (int i = 1; i < LATENCY_MULTIPLIER; i++) begin
        mul_q[i] <= mul_q[i-1];
      end
    end
  end

  assign product_ext = WORD_WIDTH_ACC'(mul_q[LATENCY_MULTIPLIER-1]);  // sign extends.

  // bypass drops the old partial sum and starts the group from this product.
  always_ff @(posedge clk) begin
    if (i_en) begin
      o_sum <= i_bypass ? product_ext : o_sum + product_ext;
    end
  end

  // the sum waiting for the output register must not move during a stall.
  a_sum_held: assert property (@(posedge clk) disable iff (!i_rst_n)
    !i_en |=> $stable(o_sum));

endmodule

`default_nettype wire

/* source/pe_controller.sv */
/*
  Control for the element grid: one enable for every stage, taken from the
  registered ready of the output buffer. The kernel-width shift path is absent,
  so every column gets the same bypass.
*/
`timescale 1ns/1ps
`default_nettype none

module pe_controller (
  input  wire                         clk,
  input  wire                         i_rst_n,
  input  wire                         i_s_valid,
  input  wire                         i_s_last,
  input  conv_pkg::tuser_st           i_s_user,
  input  wire                         i_ready,
  output logic                        o_en,
  output logic                        o_clken_mul,
  output logic [conv_pkg::COLS-1:0]   o_bypass,
  output logic                        o_acc_valid,
  output conv_pkg::acc_ctrl_st        o_acc_ctrl
);
  import conv_pkg::*;

  logic       en;
  mul_ctrl_st mul_in;
  mul_ctrl_st mul_out;
  acc_ctrl_st acc_in;
  acc_ctrl_st acc_out;

  // ====================================================================
  // enables
  // ====================================================================
  assign en          = i_ready;  // the whole pipe stalls when the buffer is full.
  assign o_en        = en;
  assign o_clken_mul = en && i_s_valid;

  // ====================================================================
  // control beside the multiplier stages
  // ====================================================================
  assign mul_in = '{valid: i_s_valid, last: i_s_last, user: i_s_user};

  n_delay #(
    .N (LATENCY_MULTIPLIER),
    .T (mul_ctrl_st)
  ) u_mul_delay (
    .clk     (clk),
    .i_rst_n (i_rst_n),
    .i_clken (en),
    .i_data  (mul_in),
    .o_data  (mul_out)
  );

  // the product leaving the multiplier opens a new sum in every column.
  assign o_bypass = {COLS{mul_out.valid && mul_out.user.is_sum_start}};

  // ====================================================================
  // control beside the accumulator stage
  // ====================================================================
  // only a closing beat produces an output, so the valid carries is_cin_last.
  assign acc_in = '{
    valid: mul_out.valid && mul_out.user.is_cin_last,
    last:  mul_out.last,
    tag:   mul_out.user.tag
  };

  n_delay #(
    .N (LATENCY_ACCUMULATOR),
    .T (acc_ctrl_st)
  ) u_acc_delay (
    .clk     (clk),
    .i_rst_n (i_rst_n),
    .i_clken (en),
    .i_data  (acc_in),
    .o_data  (acc_out)
  );

  assign o_acc_valid = acc_out.valid;
  assign o_acc_ctrl  = acc_out;

  // a new sum can only reach the output register on a cycle the pipe moved.
  a_acc_valid_rise: assert property (@(posedge clk) disable iff (!i_rst_n)
    $rose(o_acc_valid) |-> $past(en));

endmodule

`default_nettype wire

/* source/skid_buffer.sv */
/*
  Two-entry output buffer with a registered ready. When ready falls, the one
  beat already in flight goes to the spare entry, and ready comes back only
  after the spare has moved into the main register.
*/
`timescale 1ns/1ps
`default_nettype none

module skid_buffer (
  input  wire                   clk,
  input  wire                   i_rst_n,
  input  wire                   i_s_valid,
  output logic                  o_s_ready,
  input  conv_pkg::out_beat_st  i_s_data,
  output logic                  o_m_valid,
  input  wire                   i_m_ready,
  output conv_pkg::out_beat_st  o_m_data
);
  import conv_pkg::*;

  out_beat_st spare_q;
  logic       in_xfer;

  assign in_xfer = i_s_valid && o_s_ready;

  // ====================================================================
  // control where a low ready means the spare entry is full
  // ====================================================================
  always_ff @(posedge clk) begin
    if (!i_rst_n) begin
      o_m_valid <= 1'b0;
      o_s_ready <= 1'b1;
    end else if (!o_s_ready) begin
      if (i_m_ready) begin
        o_s_ready <= 1'b1;  // spare moves up and main stays valid.
      end
    end else if (in_xfer) begin
      o_m_valid <= 1'b1;
      if (o_m_valid && !i_m_ready) begin
        o_s_ready <= 1'b0;  // the incoming beat lands in the spare.
      end
    end else if (i_m_ready) begin
      o_m_valid <= 1'b0;
    end
  end

  // ====================================================================
  // payload
  // ====================================================================
  always_ff @(posedge clk) begin
    if (!o_s_ready) begin
      if (i_m_ready) begin
        o_m_data <= spare_q;
      end
    end else if (in_xfer) begin
      if (!o_m_valid || i_m_ready) begin
        o_m_data <= i_s_data;
      end else begin
        spare_q <= i_s_data;
      end
    end
  end

  a_hold_on_stall: assert property (@(posedge clk) disable iff (!i_rst_n)
    (o_m_valid && !i_m_ready) |=> (o_m_valid && $stable(o_m_data)));

  // both entries full means ready is low, so a third beat is never taken.
  a_spare_needs_main: assert property (@(posedge clk) disable iff (!i_rst_n)
    !o_s_ready |-> o_m_valid);

endmodule

`default_nettype wire

/* source/proc_engine.sv */
/*
  Processing engine top: ROWS by COLS multiply-accumulate grid with stream
  input and output. Input is taken only while the output buffer has room, and
  only groups closed by is_cin_last produce an output beat.
*/
`timescale 1ns/1ps
`default_nettype none

module proc_engine (
  input  wire                   clk,
  input  wire                   i_rst_n,
  input  wire                   i_s_valid,
  output logic                  o_s_ready,
  input  conv_pkg::in_beat_st   i_s_beat,
  output logic                  o_m_valid,
  input  wire                   i_m_ready,
  output conv_pkg::out_beat_st  o_m_beat
);
  import conv_pkg::*;

  logic            en;
  logic            clken_mul;
  logic [COLS-1:0] bypass;
  logic            acc_valid;
  logic            buf_ready;
  acc_ctrl_st      acc_ctrl;
  out_beat_st      acc_beat;

  wire [COLS-1:0][ROWS-1:0][WORD_WIDTH_ACC-1:0] sum_grid;

  assign o_s_ready = en;

  pe_controller u_ctrl (
    .clk         (clk),
    .i_rst_n     (i_rst_n),
    .i_s_valid   (i_s_valid),
    .i_s_last    (i_s_beat.last),
    .i_s_user    (i_s_beat.user),
    .i_ready     (buf_ready),
    .o_en        (en),
    .o_clken_mul (clken_mul),
    .o_bypass    (bypass),
    .o_acc_valid (acc_valid),
    .o_acc_ctrl  (acc_ctrl)
  );

  // ====================================================================
  // element grid with one pixel per row and one weight per column
  // ====================================================================
  for (genvar c = 0; c < COLS; c++) begin : g_col
    for (genvar r = 0; r < ROWS; r++) begin : g_row
      proc_element u_pe (
        .clk         (clk),
        .i_rst_n     (i_rst_n),
        .i_en        (en),
        .i_clken_mul (clken_mul),
        .i_pixel     (i_s_beat.pixels[r]),
        .i_weight    (i_s_beat.weights[c]),
        .i_bypass    (bypass[c]),
        .o_sum       (sum_grid[c][r])
      );
    end
  end

  assign acc_beat = '{sums: sum_grid, tag: acc_ctrl.tag, last: acc_ctrl.last};

  skid_buffer u_out_buf (
    .clk       (clk),
    .i_rst_n   (i_rst_n),
    .i_s_valid (acc_valid),
    .o_s_ready (buf_ready),
    .i_s_data  (acc_beat),
    .o_m_valid (o_m_valid),
    .i_m_ready (i_m_ready),
    .o_m_data  (o_m_beat)
  );

endmodule

`default_nettype wire

/* verif/clk_gen.sv */
/*
  Testbench clock of 8 ns period. Reset is low through the first 3 rising
  edges and is released 1 ns after the third.
*/
`timescale 1ns/1ps
`default_nettype none

module clk_gen (
  output logic o_clk,
  output logic o_rst_n
);

  initial begin
    o_clk = 1'b0;
    forever #4 o_clk = ~o_clk;
  end

  initial begin
    o_rst_n = 1'b0;
    repeat (3) @(posedge o_clk);
    #1 o_rst_n = 1'b1;  // released away from the edge.
  end

endmodule

`default_nettype wire

/* verif/tb_proc_engine.sv */
/*
  Random groups of 1 to 5 beats against a per-element reference sum, with
  random input gaps and output stalls. The first group is a lone beat sent
  with the sink always ready, to measure the latency.
*/
`timescale 1ns/1ps
`default_nettype none

module tb_proc_engine;
  import conv_pkg::*;

  localparam int NUM_GROUPS      = 40;
  localparam int CYCLES_PER_BEAT = 20;
  localparam int SEED            = 1;

  logic       clk;
  logic       rst_n;
  logic       i_s_valid;
  logic       o_s_ready;
  in_beat_st  i_s_beat;
  logic       o_m_valid;
  logic       i_m_ready;
  out_beat_st o_m_beat;

  in_beat_st  beat_q [$];
  int         gap_q [$];
  out_beat_st exp_q [$];
  int         acc_model [COLS][ROWS];
  int         beats_out     = 0;
  int         lat_cycles    = 0;
  bit         lat_armed     = 1'b0;
  bit         lat_counting  = 1'b0;
  bit         lat_checked   = 1'b0;
  bit         reset_checked = 1'b0;
  bit         stall_prev    = 1'b0;
  bit         random_stalls = 1'b0;
  out_beat_st held_beat;

  clk_gen u_clk_gen (
    .o_clk   (clk),
    .o_rst_n (rst_n)
  );

  proc_engine UUT (
    .clk       (clk),
    .i_rst_n   (rst_n),
    .i_s_valid (i_s_valid),
    .o_s_ready (o_s_ready),
    .i_s_beat  (i_s_beat),
    .o_m_valid (o_m_valid),
    .i_m_ready (i_m_ready),
    .o_m_beat  (o_m_beat)
  );

  task automatic stop_on_error(input string msg);
    $display("%s", msg);
    $display("TESTBENCH FAILED");
    $fatal(1, "run stopped at the first error");
  endtask

  // ======================================================================
  // stimulus
  // ======================================================================
  task automatic build_stimulus();
    in_beat_st beat;
    int        len;
    for (int g = 0; g < NUM_GROUPS; g++) begin
      len = (g == 0) ? 1 : int'($urandom_range(1, 5));
      for (int b = 0; b < len; b++) begin
        for (int r = 0; r < ROWS; r++) begin
          beat.pixels[r] = WORD_WIDTH'($urandom());
        end
        for (int c = 0; c < COLS; c++) begin
          beat.weights[c] = WORD_WIDTH'($urandom());
        end
        beat.user.is_sum_start = (b == 0);
        beat.user.is_cin_last  = (b == len - 1);
        beat.user.tag          = TAG_WIDTH'(g);
        beat.last              = (b == len - 1) && ($urandom_range(0, 1) == 1);
        beat_q.push_back(beat);
        gap_q.push_back(($urandom_range(0, 1) == 0) ? 0 : int'($urandom_range(1, 3)));
      end
    end
  endtask

  // entered and left 1 ns after a rising edge.
  task automatic send_beat(input in_beat_st beat, input int gap);
    i_s_valid = 1'b0;
    repeat (gap) begin
      @(posedge clk);
      #1;
    end
    i_s_beat  = beat;
    i_s_valid = 1'b1;
    @(posedge clk);
    while (!o_s_ready) @(posedge clk);
    #1;
    i_s_valid = 1'b0;
  endtask

  task automatic wait_for_drain();
    do begin
      @(posedge clk);
      #1;
    end while (exp_q.size() != 0);
  endtask

  task automatic run_watchdog(input int limit);
    repeat (limit) @(posedge clk);
    stop_on_error($sformatf("timeout: the run did not end within %0d cycles", limit));
  endtask

  // ======================================================================
  // reference model and checks on values sampled at the rising edge
  // ======================================================================
  task automatic model_input_beat();
    out_beat_st exp_beat;
    int         prod;
    if (i_s_valid && o_s_ready) begin
      for (int c = 0; c < COLS; c++) begin
        for (int r = 0; r < ROWS; r++) begin
          prod = int'($signed(i_s_beat.pixels[r])) * int'($signed(i_s_beat.weights[c]));
          acc_model[c][r] = i_s_beat.user.is_sum_start ? prod : acc_model[c][r] + prod;
          exp_beat.sums[c][r] = WORD_WIDTH_ACC'(acc_model[c][r]);
        end
      end
      exp_beat.tag  = i_s_beat.user.tag;
      exp_beat.last = i_s_beat.last;
      if (i_s_beat.user.is_cin_last) begin
        exp_q.push_back(exp_beat);  // one output per closed group.
      end
    end
  endtask

  task automatic score_output_beat();
    out_beat_st exp_beat;
    if (o_m_valid && i_m_ready) begin
      assert (exp_q.size() != 0)
        else stop_on_error("an output beat arrived with no closed group waiting for it");
      exp_beat = exp_q.pop_front();
      for (int c = 0; c < COLS; c++) begin
        for (int r = 0; r < ROWS; r++) begin
          assert (o_m_beat.sums[c][r] == exp_beat.sums[c][r])
            else stop_on_error($sformatf("[ERROR] o_m_beat.sums[%0d][%0d] got 0x%h expected 0x%h",
              c, r, o_m_beat.sums[c][r], exp_beat.sums[c][r]));
        end
      end
      assert (o_m_beat.tag == exp_beat.tag)
        else stop_on_error($sformatf("[ERROR] o_m_beat.tag got 0x%h expected 0x%h",
          o_m_beat.tag, exp_beat.tag));
      assert (o_m_beat.last == exp_beat.last)
        else stop_on_error($sformatf("[ERROR] o_m_beat.last got 0x%h expected 0x%h",
          o_m_beat.last, exp_beat.last));
      beats_out++;
    end
  endtask

  task automatic verify_stall_hold();
    if (stall_prev) begin
      assert (o_m_beat == held_beat)
        else stop_on_error($sformatf("[ERROR] o_m_beat got 0x%h expected 0x%h under stall",
          o_m_beat, held_beat));
    end
    stall_prev = o_m_valid && !i_m_ready;
    held_beat  = o_m_beat;
  endtask

  task automatic inspect_reset_state();
    if (!reset_checked) begin
      assert (!o_m_valid)
        else stop_on_error($sformatf("[ERROR] o_m_valid got 0x%h expected 0x0 after reset",
          o_m_valid));
      assert (o_s_ready)
        else stop_on_error($sformatf("[ERROR] o_s_ready got 0x%h expected 0x1 after reset",
          o_s_ready));
      reset_checked = 1'b1;
    end
  endtask

  // four registers in the path and the first one loads at the accepting edge.
  task automatic measure_latency();
    if (lat_counting) begin
      lat_cycles++;
      if (o_m_valid || lat_cycles >= 4) begin
        assert (o_m_valid && lat_cycles == 4)
          else stop_on_error($sformatf(
            "[ERROR] o_m_valid got 0x%h at cycle 0x%h, expected 0x1 at 0x4",
            o_m_valid, lat_cycles));
        lat_counting = 1'b0;
        lat_checked  = 1'b1;
      end
    end
    if (lat_armed && i_s_valid && o_s_ready) begin
      lat_counting = 1'b1;
      lat_cycles   = 0;
    end
  endtask

  always @(posedge clk) begin : monitor
    if (rst_n) begin
      inspect_reset_state();
      verify_stall_hold();
      score_output_beat();
      model_input_beat();
      measure_latency();
    end
  end

  a_valid_held: assert property (@(posedge clk) disable iff (!rst_n)
    (o_m_valid && !i_m_ready) |=> o_m_valid)
    else stop_on_error("[ERROR] o_m_valid got 0x0 expected 0x1 after a stalled cycle");

  // the sink stalls about one cycle in three while random stalls are on.
  initial begin : sink
    forever begin
      @(posedge clk);
      #1;
      i_m_ready = random_stalls ? ($urandom_range(0, 2) != 0) : 1'b1;
    end
  end

  initial begin : main
    in_beat_st beat;
    int        gap;
    void'($urandom(SEED));
    i_s_valid = 1'b0;
    i_s_beat  = '0;
    i_m_ready = 1'b1;
    build_stimulus();
    fork
      run_watchdog(beat_q.size() * CYCLES_PER_BEAT);
    join_none
    @(posedge rst_n);
    @(posedge clk);
    #1;

    lat_armed = 1'b1;
    beat      = beat_q.pop_front();
    gap       = gap_q.pop_front();
    send_beat(beat, gap);
    lat_armed = 1'b0;
    wait_for_drain();
    assert (lat_checked) else stop_on_error("the latency probe never saw its output beat");

    random_stalls = 1'b1;
    while (beat_q.size() != 0) begin
      beat = beat_q.pop_front();
      gap  = gap_q.pop_front();
      send_beat(beat, gap);
    end
    random_stalls = 1'b0;
    wait_for_drain();
    repeat (10) @(posedge clk);  // room for a stray duplicate to show up.

    if (exp_q.size() == 0 && beats_out == NUM_GROUPS) begin
      $display("TESTBENCH PASSED");
      $finish;
    end else begin
      stop_on_error($sformatf("%0d output beats seen for %0d groups", beats_out, NUM_GROUPS));
    end
  end

endmodule

`default_nettype wire

/* project.f */
source/conv_pkg.sv
source/n_delay.sv
source/proc_element.sv
source/pe_controller.sv
source/skid_buffer.sv
source/proc_engine.sv
verif/clk_gen.sv
verif/tb_proc_engine.sv

/* run.sh */
#!/bin/sh
# Builds the processing engine testbench with Verilator and runs it.
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
  --top-module tb_proc_engine -f project.f -o tb_proc_engine

./obj_dir/tb_proc_engine > sim.log 2>&1 || true
cat sim.log

if grep -qx "TESTBENCH PASSED" sim.log; then
  echo "run.sh: simulation passed"
else
  echo "run.sh: simulation failed"
  exit 1
fi
